//--- source/nocPkg.sv
package nocPkg;

  // Flit kinds are one-hot: header 1, body 2, tail 4.
  typedef logic [2:0] flitIdT;

  // On a header flit the payload carries the grant budget in cycles.
  typedef logic [11:0] payloadT;

  typedef logic [2:0] portIdT;

  localparam flitIdT flitHeader = 3'b001;

  localparam int numPorts = 5;

  localparam portIdT portLocal = 3'd0;
  localparam portIdT portNorth = 3'd1;
  localparam portIdT portEast = 3'd2;
  localparam portIdT portWest = 3'd3;
  localparam portIdT portSouth = 3'd4;

endpackage

//--- source/arbPkg.sv
package arbPkg;

  localparam int budgetWidth = 12;

  typedef logic [budgetWidth-1:0] budgetT;

  // One-hot, bit 0 is idle and bits 1 to 5 follow the port order.
  typedef enum logic [5:0]
  {
    idle = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage

//--- source/grantTimer.sv
`timescale 1ns/1ns

module grantTimer
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitIdT flitId,
  input  nocPkg::payloadT payload,
  input  logic holding,
  input  logic run,
  output logic timesUp
);

  arbPkg::budgetT budget;
  arbPkg::budgetT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      if (holding && flitId == nocPkg::flitHeader)
        budget <= payload; // New packet, new budget.
      if (!run)
        count <= '0;
      else
        count <= count + 1'b1;
    end
  end

  assign timesUp = (count == budget);

endmodule

//--- source/portArbiter.sv
`timescale 1ns/1ns

module portArbiter
(
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] pending,
  input  nocPkg::flitIdT flitId0,
  input  nocPkg::flitIdT flitId1,
  input  nocPkg::flitIdT flitId2,
  input  nocPkg::flitIdT flitId3,
  input  nocPkg::flitIdT flitId4,
  input  nocPkg::payloadT payload0,
  input  nocPkg::payloadT payload1,
  input  nocPkg::payloadT payload2,
  input  nocPkg::payloadT payload3,
  input  nocPkg::payloadT payload4,
  output arbPkg::arbStateT grant
);

  arbPkg::arbStateT state;
  arbPkg::arbStateT nextState;
  nocPkg::flitIdT [nocPkg::numPorts-1:0] flitIdArr;
  nocPkg::payloadT [nocPkg::numPorts-1:0] payloadArr;
  logic [nocPkg::numPorts-1:0] granted;
  logic [nocPkg::numPorts-1:0] runTimer;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [2:0] startIdx;
  logic [2:0] idx;
  logic found;

  assign flitIdArr = {flitId4, flitId3, flitId2, flitId1, flitId0};
  assign payloadArr = {payload4, payload3, payload2, payload1, payload0};
  assign granted = state[5:1];

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genTimer
    grantTimer timerInst
    (
      .clk(clk),
      .rst(rst),
      .flitId(flitIdArr[i]),
      .payload(payloadArr[i]),
      .holding(pending[i]),
      .run(runTimer[i]),
      .timesUp(timesUp[i])
    );
  end

  // Search begins after the current owner; idle behaves like South so L is checked first.
  always_comb
  begin
    case (state)
      arbPkg::grantL: startIdx = 3'd0;
      arbPkg::grantN: startIdx = 3'd1;
      arbPkg::grantE: startIdx = 3'd2;
      arbPkg::grantW: startIdx = 3'd3;
      default: startIdx = 3'd4;
    endcase
  end

  always_comb
  begin
    nextState = arbPkg::idle;
    runTimer = '0;
    found = 1'b0;
    idx = '0;
    if (|(granted & pending & ~timesUp))
    begin
      nextState = state; // Owner keeps the output.
      runTimer = granted;
    end
    else
    begin
      for (int k = 1; k <= nocPkg::numPorts; k++)
      begin
        idx = 3'((32'(startIdx) + k) % nocPkg::numPorts);
        if (!found && pending[idx])
        begin
          found = 1'b1;
          nextState = arbPkg::arbStateT'(6'b000010 << idx);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbPkg::idle;
    else
      state <= nextState;
  end

  assign grant = state;

endmodule

//--- source/inputLink.sv
`timescale 1ns/1ns

module inputLink
(
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  nocPkg::flitIdT flitIdIn,
  input  nocPkg::payloadT payloadIn,
  output logic ack,
  output logic pending,
  output nocPkg::flitIdT flitId,
  output nocPkg::payloadT payload,
  input  logic pop
);

  typedef enum logic [1:0]
  {
    linkIdle,
    linkCapture,
    linkAck
  } linkStateT;

  linkStateT state;
  logic accept;

  // A full holding register keeps ack low, which stalls the sender.
  assign accept = (state == linkIdle) && req && !pending;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      flitId <= flitIdIn;
      payload <= payloadIn;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= linkIdle;
      ack <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      if (pop)
        pending <= 1'b0;
      case (state)
        linkIdle:
        begin
          if (accept)
          begin
            pending <= 1'b1;
            state <= linkCapture;
          end
        end
        linkCapture:
        begin
          ack <= 1'b1; // Flit is safe, release the sender.
          state <= linkAck;
        end
        linkAck:
        begin
          if (!req)
          begin
            ack <= 1'b0;
            state <= linkIdle;
          end
        end
        default:
        begin
          ack <= 1'b0;
          state <= linkIdle;
        end
      endcase
    end
  end

endmodule

//--- source/outputLink.sv
`timescale 1ns/1ns

module outputLink
(
  input  logic clk,
  input  logic rst,
  input  arbPkg::arbStateT grant,
  input  logic [nocPkg::numPorts-1:0] pending,
  input  nocPkg::flitIdT flitId0,
  input  nocPkg::flitIdT flitId1,
  input  nocPkg::flitIdT flitId2,
  input  nocPkg::flitIdT flitId3,
  input  nocPkg::flitIdT flitId4,
  input  nocPkg::payloadT payload0,
  input  nocPkg::payloadT payload1,
  input  nocPkg::payloadT payload2,
  input  nocPkg::payloadT payload3,
  input  nocPkg::payloadT payload4,
  output logic [nocPkg::numPorts-1:0] pop,
  output logic outReq,
  input  logic outAck,
  output nocPkg::flitIdT outFlitId,
  output nocPkg::payloadT outPayload,
  output nocPkg::portIdT outSrc
);

  typedef enum logic [1:0]
  {
    txIdle,
    txSend,
    txRelease
  } txStateT;

  txStateT state;
  logic [nocPkg::numPorts-1:0] granted;
  logic take;
  nocPkg::flitIdT selFlitId;
  nocPkg::payloadT selPayload;
  nocPkg::portIdT selSrc;

  assign granted = grant[5:1];
  assign take = (state == txIdle) && |(granted & pending);
  assign pop = take ? (granted & pending) : '0;

  always_comb
  begin
    selFlitId = flitId0;
    selPayload = payload0;
    selSrc = nocPkg::portLocal;
    case (grant)
      arbPkg::grantN:
      begin
        selFlitId = flitId1;
        selPayload = payload1;
        selSrc = nocPkg::portNorth;
      end
      arbPkg::grantE:
      begin
        selFlitId = flitId2;
        selPayload = payload2;
        selSrc = nocPkg::portEast;
      end
      arbPkg::grantW:
      begin
        selFlitId = flitId3;
        selPayload = payload3;
        selSrc = nocPkg::portWest;
      end
      arbPkg::grantS:
      begin
        selFlitId = flitId4;
        selPayload = payload4;
        selSrc = nocPkg::portSouth;
      end
      default:
      begin
        selSrc = nocPkg::portLocal; // Local, and don't care when idle.
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outFlitId <= selFlitId;
      outPayload <= selPayload;
      outSrc <= selSrc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= txIdle;
      outReq <= 1'b0;
    end
    else
    begin
      case (state)
        txIdle:
        begin
          if (take)
          begin
            outReq <= 1'b1;
            state <= txSend;
          end
        end
        txSend:
        begin
          if (outAck)
          begin
            outReq <= 1'b0;
            state <= txRelease;
          end
        end
        txRelease:
        begin
          if (!outAck)
            state <= txIdle; // Receiver finished its half.
        end
        default:
        begin
          outReq <= 1'b0;
          state <= txIdle;
        end
      endcase
    end
  end

endmodule

//--- source/routerOutput.sv
`timescale 1ns/1ns

module routerOutput
(
  input  logic clk,
  input  logic rst,
  input  logic LReq,
  output logic LAck,
  input  nocPkg::flitIdT LFlitId,
  input  nocPkg::payloadT LPayload,
  input  logic NReq,
  output logic NAck,
  input  nocPkg::flitIdT NFlitId,
  input  nocPkg::payloadT NPayload,
  input  logic EReq,
  output logic EAck,
  input  nocPkg::flitIdT EFlitId,
  input  nocPkg::payloadT EPayload,
  input  logic WReq,
  output logic WAck,
  input  nocPkg::flitIdT WFlitId,
  input  nocPkg::payloadT WPayload,
  input  logic SReq,
  output logic SAck,
  input  nocPkg::flitIdT SFlitId,
  input  nocPkg::payloadT SPayload,
  output logic outReq,
  input  logic outAck,
  output nocPkg::flitIdT outFlitId,
  output nocPkg::payloadT outPayload,
  output nocPkg::portIdT outSrc
);

  logic [nocPkg::numPorts-1:0] pending;
  logic [nocPkg::numPorts-1:0] pop;
  nocPkg::flitIdT flitId0, flitId1, flitId2, flitId3, flitId4;
  nocPkg::payloadT payload0, payload1, payload2, payload3, payload4;
  arbPkg::arbStateT grant;

  inputLink linkL (.clk(clk), .rst(rst), .req(LReq), .flitIdIn(LFlitId), .payloadIn(LPayload),
    .ack(LAck), .pending(pending[0]), .flitId(flitId0), .payload(payload0), .pop(pop[0]));
  inputLink linkN (.clk(clk), .rst(rst), .req(NReq), .flitIdIn(NFlitId), .payloadIn(NPayload),
    .ack(NAck), .pending(pending[1]), .flitId(flitId1), .payload(payload1), .pop(pop[1]));
  inputLink linkE (.clk(clk), .rst(rst), .req(EReq), .flitIdIn(EFlitId), .payloadIn(EPayload),
    .ack(EAck), .pending(pending[2]), .flitId(flitId2), .payload(payload2), .pop(pop[2]));
  inputLink linkW (.clk(clk), .rst(rst), .req(WReq), .flitIdIn(WFlitId), .payloadIn(WPayload),
    .ack(WAck), .pending(pending[3]), .flitId(flitId3), .payload(payload3), .pop(pop[3]));
  inputLink linkS (.clk(clk), .rst(rst), .req(SReq), .flitIdIn(SFlitId), .payloadIn(SPayload),
    .ack(SAck), .pending(pending[4]), .flitId(flitId4), .payload(payload4), .pop(pop[4]));

  portArbiter arbInst (.clk(clk), .rst(rst), .pending(pending),
    .flitId0(flitId0), .flitId1(flitId1), .flitId2(flitId2), .flitId3(flitId3),
    .flitId4(flitId4), .payload0(payload0), .payload1(payload1), .payload2(payload2),
    .payload3(payload3), .payload4(payload4), .grant(grant));

  outputLink outInst (.clk(clk), .rst(rst), .grant(grant), .pending(pending),
    .flitId0(flitId0), .flitId1(flitId1), .flitId2(flitId2), .flitId3(flitId3),
    .flitId4(flitId4), .payload0(payload0), .payload1(payload1), .payload2(payload2),
    .payload3(payload3), .payload4(payload4), .pop(pop), .outReq(outReq), .outAck(outAck),
    .outFlitId(outFlitId), .outPayload(outPayload), .outSrc(outSrc));

endmodule

//--- tests/routerOutput_assert.sv
`timescale 1ns/1ns

module routerOutputProtocolChecks
(
  input  logic clk,
  input  logic rst,
  input  logic [4:0] reqs,
  input  logic [4:0] acks,
  input  logic outReq,
  input  logic outAck,
  input  logic [5:0] grant,
  input  nocPkg::payloadT outPayload
);

  // An input ack may only rise on a high req and fall on a low one.
  ackRiseOrder: assert property (@(posedge clk) disable iff (rst)
    (acks & ~$past(acks) & ~$past(reqs)) == 5'b0)
    else $error("Input ack rose without a request");

  ackFallOrder: assert property (@(posedge clk) disable iff (rst)
    (~acks & $past(acks) & $past(reqs)) == 5'b0)
    else $error("Input ack fell while the request was still high");

  outReqRise: assert property (@(posedge clk) disable iff (rst)
    $rose(outReq) |-> !$past(outAck))
    else $error("Output req rose before the previous ack was released");

  outReqFall: assert property (@(posedge clk) disable iff (rst)
    $fell(outReq) |-> $past(outAck))
    else $error("Output req fell without an ack");

  grantLegal: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("Grant left the six legal encodings");

  payloadStable: assert property (@(posedge clk) disable iff (rst)
    (outReq && $past(outReq)) |-> $stable(outPayload))
    else $error("Output payload changed while req was high");

endmodule

bind routerOutput routerOutputProtocolChecks protocolChecks
(
  .clk(clk),
  .rst(rst),
  .reqs({SReq, WReq, EReq, NReq, LReq}),
  .acks({SAck, WAck, EAck, NAck, LAck}),
  .outReq(outReq),
  .outAck(outAck),
  .grant(grant),
  .outPayload(outPayload)
);

//--- tests/routerOutputTb.sv
`timescale 1ns/1ns

module routerOutputTb;

  logic clk;
  logic rst;
  logic [4:0] reqV;
  logic [4:0] ackV;
  nocPkg::flitIdT flitIdV [5];
  nocPkg::payloadT payloadV [5];
  logic outReq;
  logic outAck;
  nocPkg::flitIdT outFlitId;
  nocPkg::payloadT outPayload;
  nocPkg::portIdT outSrc;

  nocPkg::flitIdT sendFlit [5][$];
  nocPkg::payloadT sendPay [5][$];
  nocPkg::flitIdT expFlit [5][$];
  nocPkg::payloadT expPay [5][$];
  int maxBudget [5];
  int ackCount [5];
  int outCount [5];
  int flitTotal;
  int outTotal;
  logic [31:0] rngState;
  logic [5:0] prevGrant;
  logic [4:0] prevPending;
  int holdLen;
  logic checkAfterReset;

  routerOutput routerOutput_inst
  (
    .clk(clk), .rst(rst),
    .LReq(reqV[0]), .LAck(ackV[0]), .LFlitId(flitIdV[0]), .LPayload(payloadV[0]),
    .NReq(reqV[1]), .NAck(ackV[1]), .NFlitId(flitIdV[1]), .NPayload(payloadV[1]),
    .EReq(reqV[2]), .EAck(ackV[2]), .EFlitId(flitIdV[2]), .EPayload(payloadV[2]),
    .WReq(reqV[3]), .WAck(ackV[3]), .WFlitId(flitIdV[3]), .WPayload(payloadV[3]),
    .SReq(reqV[4]), .SAck(ackV[4]), .SFlitId(flitIdV[4]), .SPayload(payloadV[4]),
    .outReq(outReq), .outAck(outAck), .outFlitId(outFlitId), .outPayload(outPayload),
    .outSrc(outSrc)
  );

  always #5 clk = ~clk;

  task automatic failWith(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Next owner is the first pending port after the current one in circular order.
  function automatic logic [5:0] nextOwner(input logic [5:0] g, input logic [4:0] pend);
    int start;
    int idx;
    start = 4;
    for (int i = 0; i < 5; i++)
      if (g[i+1])
        start = i;
    for (int k = 1; k <= 5; k++)
    begin
      idx = (start + k) % 5;
      if (pend[idx])
        return 6'b000010 << idx;
    end
    return 6'b000001;
  endfunction

  function automatic int ownerOf(input logic [5:0] g);
    for (int i = 0; i < 5; i++)
      if (g[i+1])
        return i;
    return 0;
  endfunction

  task automatic driveInput(input int p);
    int gap;
    while (sendFlit[p].size() > 0)
    begin
      gap = ((nextRandom() % 4) == 0) ? int'(nextRandom() % 3) : 0; // Mostly saturated.
      repeat (gap) @(negedge clk);
      flitIdV[p] = sendFlit[p].pop_front();
      payloadV[p] = sendPay[p].pop_front();
      reqV[p] = 1'b1;
      @(negedge clk);
      while (!ackV[p])
        @(negedge clk);
      ackCount[p]++;
      assert (ackCount[p] <= outCount[p] + 1)
        else failWith($sformatf("Port %0d took a flit while its held flit was unsent", p));
      reqV[p] = 1'b0;
      @(negedge clk);
      while (ackV[p])
        @(negedge clk);
    end
  endtask

  task automatic receiveOutput();
    int delay;
    int src;
    forever
    begin
      @(negedge clk);
      if (outReq)
      begin
        src = int'(outSrc);
        assert (src < 5) else failWith($sformatf("ERR outSrc got %h", outSrc));
        assert (expFlit[src].size() > 0)
          else failWith($sformatf("Port %0d sent more flits than the test holds", src));
        assert (outFlitId == expFlit[src][0])
          else failWith($sformatf("ERR outFlitId expected %h got %h", expFlit[src][0], outFlitId));
        assert (outPayload == expPay[src][0])
          else failWith($sformatf("ERR outPayload expected %h got %h", expPay[src][0], outPayload));
        void'(expFlit[src].pop_front());
        void'(expPay[src].pop_front());
        outCount[src]++;
        // Second half of the run uses long ack delays for back-pressure.
        if (outTotal >= flitTotal / 2)
          delay = 4 + int'(nextRandom() % 16);
        else
          delay = int'(nextRandom() % 3);
        repeat (delay) @(negedge clk);
        outAck = 1'b1;
        while (outReq)
          @(negedge clk);
        outAck = 1'b0;
        outTotal++;
      end
    end
  endtask

  always @(negedge clk)
  begin : grantMonitor
    logic [5:0] curGrant;
    logic [5:0] expGrant;
    int owner;
    if (rst)
    begin
      assert (outReq == 1'b0 && ackV == 5'b0)
        else failWith($sformatf("ERR outReq %h ackV %h expected 0 during reset", outReq, ackV));
      checkAfterReset = 1'b1;
      prevGrant = 6'b000001;
      prevPending = '0;
      holdLen = 0;
    end
    else
    begin
      if (checkAfterReset)
      begin
        assert (outReq == 1'b0 && ackV == 5'b0)
          else failWith($sformatf("ERR outReq %h ackV %h expected 0 after reset", outReq, ackV));
        checkAfterReset = 1'b0;
      end
      curGrant = routerOutput_inst.grant;
      if (curGrant != prevGrant)
      begin
        expGrant = nextOwner(prevGrant, prevPending);
        assert (curGrant == expGrant)
          else failWith($sformatf("ERR grant expected %h got %h", expGrant, curGrant));
        holdLen = 1;
      end
      else if (curGrant != 6'b000001)
      begin
        owner = ownerOf(curGrant);
        if ((prevPending & ~(5'b00001 << owner)) != 5'b0)
          holdLen++;
        else
          holdLen = 1; // Nobody else waited, so no rotation was due.
        assert (holdLen <= maxBudget[owner] + 1)
          else failWith($sformatf("Port %0d kept the grant past its budget", owner));
      end
      prevGrant = curGrant;
      prevPending = routerOutput_inst.pending;
    end
  end

  initial
  begin
    int fd;
    int cnt;
    int p;
    int f;
    int d;
    string line;
    clk = 1'b0;
    rst <= 1'b1;
    reqV = '0;
    outAck = 1'b0;
    for (int i = 0; i < 5; i++)
    begin
      flitIdV[i] = '0;
      payloadV[i] = '0;
      maxBudget[i] = 0;
      ackCount[i] = 0;
      outCount[i] = 0;
    end
    rngState = 32'hcc1c_6de5;
    flitTotal = 0;
    outTotal = 0;
    checkAfterReset = 1'b0;
    fd = $fopen("tests/routerOutputTests.txt", "r");
    if (fd == 0)
      failWith("Cannot open the test data file");
    while (!$feof(fd))
    begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 0 && line.getc(0) != 8'h23)
      begin
        if ($sscanf(line, "%h %h %h", p, f, d) == 3)
        begin
          sendFlit[p].push_back(nocPkg::flitIdT'(f));
          sendPay[p].push_back(nocPkg::payloadT'(d));
          expFlit[p].push_back(nocPkg::flitIdT'(f));
          expPay[p].push_back(nocPkg::payloadT'(d));
          if (nocPkg::flitIdT'(f) == nocPkg::flitHeader && d > maxBudget[p])
            maxBudget[p] = d;
          flitTotal++;
        end
      end
    end
    $fclose(fd);
    fork
      begin
        repeat (200 * flitTotal) @(posedge clk);
        failWith("Timeout: not every flit reached the output");
      end
    join_none
    repeat (5) @(negedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < 5; i++)
    begin
      automatic int port = i;
      fork
        driveInput(port);
      join_none
    end
    fork
      receiveOutput();
    join_none
    wait (outTotal == flitTotal);
    repeat (5) @(negedge clk);
    if (outReq || routerOutput_inst.pending != 5'b0)
      failWith("A flit was still in the router after the last expected one left");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- tests/routerOutputTests.txt
# port flitId payload, all hex; port 0 to 4 is Local North East West South
# flitId 1 is a header whose payload is the grant budget, 2 is body, 4 is tail
0 1 000
0 2 a01
0 2 a02
0 4 a03
0 1 000
0 2 a05
0 4 a06
1 1 000
1 2 b01
1 2 b02
1 4 b03
1 1 000
1 2 b05
1 4 b06
2 1 002
2 2 c01
2 2 c02
2 4 c03
2 1 002
2 2 c05
2 4 c06
3 1 000
3 2 d01
3 2 d02
3 4 d03
3 1 000
3 2 d05
3 4 d06
4 1 006
4 2 e01
4 2 e02
4 4 e03
4 1 006
4 2 e05
4 4 e06

//--- flist.f
source/nocPkg.sv
source/arbPkg.sv
source/grantTimer.sv
source/portArbiter.sv
source/inputLink.sv
source/outputLink.sv
source/routerOutput.sv
tests/routerOutput_assert.sv
tests/routerOutputTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the router output testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module routerOutputTb -f flist.f \
  -Mdir obj_dir -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1
